//--- logic/ttc_pkg.sv
// Timer channel shared definitions

package ttc_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int data_w   = 16; // Bus and counter width
  localparam int addr_w   = 4;  // Word address width
  localparam int status_w = 5;  // Interrupt status and enable width

  // Register word addresses
  typedef enum logic [addr_w-1:0] {
    clk_ctrl   = 4'd0,
    cntr_ctrl  = 4'd1,
    count_val  = 4'd2, // Read only
    interval   = 4'd3,
    match_1    = 4'd4,
    match_2    = 4'd5,
    match_3    = 4'd6,
    int_status = 4'd7, // Read only, cleared by a read
    int_enable = 4'd8
  } reg_addr_e;

  // Counter control word bit positions
  localparam int ctrl_dis      = 0; // Counter enable, active low
  localparam int ctrl_intv     = 1; // Interval wrap instead of full range
  localparam int ctrl_dec      = 2; // Count down
  localparam int ctrl_match    = 3; // Match events on
  localparam int ctrl_rst      = 4; // Restart, clears itself
  localparam int ctrl_wave_dis = 5; // Waveform off
  localparam int ctrl_wave_pol = 6; // Waveform active level

  localparam logic [6:0] ctrl_reset = 7'b000_0001; // Counter held off

  // Counting mode, {interval, decrement}
  typedef enum logic [1:0] {
    overflow_up   = 2'b00,
    overflow_down = 2'b01,
    interval_up   = 2'b10,
    interval_down = 2'b11
  } count_mode_e;

  // --------------------------------------------------------------------------
  // Shared structs
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic              ctrl_sel;  // Counter control write
    logic              intv_sel;  // Interval write
    logic [3:1]        match_sel; // Match register writes
    logic [data_w-1:0] data;      // Write data
  } reg_wr_t;

  // Bit order lines up with the status register
  typedef struct packed {
    logic       ovf;   // Bit 4
    logic [3:1] match; // Bits 3 to 1
    logic       intv;  // Bit 0
  } cnt_event_t;

  typedef struct packed {
    logic [data_w-1:0]      count; // Live count
    logic [6:0]             ctrl;  // Control word
    logic [data_w-1:0]      intv;  // Interval value
    logic [3:1][data_w-1:0] match; // Match values
  } tmr_view_t;

endpackage

//--- logic/ttc_reg_decode.sv
// Timer bus register decoder

module ttc_reg_decode (
  input  logic                          pclk21,
  input  logic                          n_p_reset21,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [ttc_pkg::addr_w-1:0]    paddr,
  input  logic [ttc_pkg::data_w-1:0]    pwdata,
  input  ttc_pkg::tmr_view_t            view,      // Counter registers for reads
  input  logic [ttc_pkg::status_w-1:0]  status,    // Sticky interrupt bits
  output logic [ttc_pkg::data_w-1:0]    prdata,
  output ttc_pkg::reg_wr_t              wr,        // Counter register writes
  output logic                          status_rd, // Status read strobe
  output logic                          presc_en,
  output logic [3:0]                    presc_sel,
  output logic [ttc_pkg::status_w-1:0]  int_en
);

  ttc_pkg::reg_addr_e             addr;
  logic                           wr_acc;     // Write access cycle
  logic                           rd_acc;     // Read access cycle
  logic [4:0]                     clk_ctrl_q; // Prescale enable and select
  logic [ttc_pkg::status_w-1:0]   int_en_q;
  logic [ttc_pkg::data_w-1:0]     rd_data;

  assign addr   = ttc_pkg::reg_addr_e'(paddr);
  assign wr_acc = psel & penable & pwrite;
  assign rd_acc = psel & penable & ~pwrite;

  // --------------------------------------------------------------------------
  // Write strobes, one per access
  // --------------------------------------------------------------------------
  always_comb
  begin
    wr              = '0;
    wr.data         = pwdata;
    wr.ctrl_sel     = wr_acc && (addr == ttc_pkg::cntr_ctrl);
    wr.intv_sel     = wr_acc && (addr == ttc_pkg::interval);
    wr.match_sel[1] = wr_acc && (addr == ttc_pkg::match_1);
    wr.match_sel[2] = wr_acc && (addr == ttc_pkg::match_2);
    wr.match_sel[3] = wr_acc && (addr == ttc_pkg::match_3);
  end

  assign status_rd = rd_acc && (addr == ttc_pkg::int_status); // Clears status

  // Local holding registers
  always_ff @(posedge pclk21 or negedge n_p_reset21)
  begin
    if (!n_p_reset21)
    begin
      clk_ctrl_q <= '0;  // Prescaler off
      int_en_q   <= '0;  // All interrupts masked
    end
    else
    begin
      if (wr_acc && (addr == ttc_pkg::clk_ctrl))
        clk_ctrl_q <= pwdata[4:0];
      if (wr_acc && (addr == ttc_pkg::int_enable))
        int_en_q <= pwdata[ttc_pkg::status_w-1:0];
    end
  end

  assign presc_en  = clk_ctrl_q[0];
  assign presc_sel = clk_ctrl_q[4:1];
  assign int_en    = int_en_q;

  // --------------------------------------------------------------------------
  // Read data mux
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (addr)
      ttc_pkg::clk_ctrl:   rd_data = {{(ttc_pkg::data_w-5){1'b0}}, clk_ctrl_q};
      ttc_pkg::cntr_ctrl:  rd_data = {{(ttc_pkg::data_w-7){1'b0}}, view.ctrl};
      ttc_pkg::count_val:  rd_data = view.count;
      ttc_pkg::interval:   rd_data = view.intv;
      ttc_pkg::match_1:    rd_data = view.match[1];
      ttc_pkg::match_2:    rd_data = view.match[2];
      ttc_pkg::match_3:    rd_data = view.match[3];
      ttc_pkg::int_status: rd_data = {{(ttc_pkg::data_w-ttc_pkg::status_w){1'b0}}, status};
      ttc_pkg::int_enable: rd_data = {{(ttc_pkg::data_w-ttc_pkg::status_w){1'b0}}, int_en_q};
      default:             rd_data = '0; // Unmapped words
    endcase
  end

  assign prdata = rd_acc ? rd_data : '0; // Only during a read access

endmodule

//--- logic/ttc_prescaler.sv
// Timer clock prescaler

module ttc_prescaler (
  input  logic       pclk21,
  input  logic       n_p_reset21,
  input  logic       presc_en,  // Divide on
  input  logic [3:0] presc_sel, // Divide by 2^(sel+1)
  output logic       count_en
);

  logic [ttc_pkg::data_w-1:0] div_q;     // Free running divider
  logic [ttc_pkg::data_w-1:0] mask;      // Low bits of one period
  logic [4:0]                 shift_amt;
  logic [4:0]                 cfg_q;     // Last seen settings
  logic                       cfg_chg;
  logic                       tick;      // Divider at end of period

  assign shift_amt = {1'b0, presc_sel} + 5'd1;
  assign mask      = ~({ttc_pkg::data_w{1'b1}} << shift_amt);
  assign tick      = (div_q & mask) == mask;
  assign cfg_chg   = {presc_sel, presc_en} != cfg_q;

  always_ff @(posedge pclk21 or negedge n_p_reset21)
  begin
    if (!n_p_reset21)
    begin
      div_q    <= '0;
      cfg_q    <= '0;
      count_en <= 1'b0;
    end
    else
    begin
      cfg_q <= {presc_sel, presc_en};
      if (cfg_chg)
      begin
        div_q    <= '0;        // Restart the period
        count_en <= ~presc_en;
      end
      else
      begin
        div_q    <= div_q + 1'b1;
        count_en <= ~presc_en | tick; // Every cycle when off
      end
    end
  end

endmodule

//--- logic/ttc_counter.sv
// Timer interval and match counter

module ttc_counter (
  input  logic                 pclk21,
  input  logic                 n_p_reset21,
  input  ttc_pkg::reg_wr_t     wr,       // Register writes from the bus
  input  logic                 count_en, // Prescaled count strobe
  output ttc_pkg::tmr_view_t   view,
  output ttc_pkg::cnt_event_t  evt
);

  logic [6:0]                          ctrl_q;      // Control word
  logic [ttc_pkg::data_w-1:0]          intv_q;      // Interval value
  logic [3:1][ttc_pkg::data_w-1:0]     match_q;     // Match values
  logic [ttc_pkg::data_w-1:0]          count_q;
  logic [ttc_pkg::data_w-1:0]          count_nxt;
  logic                                counting_q;  // Has counted since restart
  logic                                restart_q;   // Restart taken, clear the bit
  logic                                active;      // Events allowed
  logic                                at_zero;
  ttc_pkg::count_mode_e                mode;

  // --------------------------------------------------------------------------
  // Registers written from the bus
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk21 or negedge n_p_reset21)
  begin
    if (!n_p_reset21)
    begin
      ctrl_q  <= ttc_pkg::ctrl_reset;
      intv_q  <= '0;
      match_q <= '0;
    end
    else
    begin
      if (wr.ctrl_sel)
        ctrl_q <= wr.data[6:0];
      else if (restart_q)
        ctrl_q[ttc_pkg::ctrl_rst] <= 1'b0;     // Restart lasts one count
      if (wr.intv_sel)
        intv_q <= wr.data;
      for (int i = 1; i <= 3; i++)
      begin
        if (wr.match_sel[i])
          match_q[i] <= wr.data;
      end
    end
  end

  // Mode straight from the control bits
  assign mode = ttc_pkg::count_mode_e'({ctrl_q[ttc_pkg::ctrl_intv], ctrl_q[ttc_pkg::ctrl_dec]});

  // --------------------------------------------------------------------------
  // Next count for a running counter
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (mode)
      ttc_pkg::interval_up:
        count_nxt = (count_q == intv_q) ? '0 : count_q + 1'b1;        // Wrap at interval
      ttc_pkg::interval_down:
        count_nxt = (count_q == '0) ? intv_q : count_q - 1'b1;        // Reload after 0
      ttc_pkg::overflow_down:
        count_nxt = count_q - 1'b1;                                   // 0 rolls to FFFF
      default:
        count_nxt = count_q + 1'b1;                                   // FFFF rolls to 0
    endcase
  end

  // Counter itself, moves only on count_en
  always_ff @(posedge pclk21 or negedge n_p_reset21)
  begin
    if (!n_p_reset21)
    begin
      count_q    <= '0;
      counting_q <= 1'b0;
      restart_q  <= 1'b0;
    end
    else if (count_en)
    begin
      if (ctrl_q[ttc_pkg::ctrl_rst])
      begin
        // Restart value depends on direction
        if (!ctrl_q[ttc_pkg::ctrl_dec])
          count_q <= '0;
        else if (ctrl_q[ttc_pkg::ctrl_intv])
          count_q <= intv_q;
        else
          count_q <= '1;
        counting_q <= 1'b0;
        restart_q  <= 1'b1;
      end
      else
      begin
        if (!ctrl_q[ttc_pkg::ctrl_dis])          // Enable is active low
        begin
          count_q    <= count_nxt;
          counting_q <= 1'b1;
        end
        restart_q <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Event levels
  // --------------------------------------------------------------------------
  assign active  = counting_q & ~ctrl_q[ttc_pkg::ctrl_rst] & ~ctrl_q[ttc_pkg::ctrl_dis];
  assign at_zero = count_q == '0;

  always_comb
  begin
    evt.intv = ctrl_q[ttc_pkg::ctrl_intv] & at_zero & active;   // Interval wrap
    evt.ovf  = ~ctrl_q[ttc_pkg::ctrl_intv] & at_zero & active;  // Full range wrap
    for (int i = 1; i <= 3; i++)
    begin
      evt.match[i] = ctrl_q[ttc_pkg::ctrl_match] & (count_q == match_q[i]) & active;
    end
  end

  // Register view for reads and the event block
  always_comb
  begin
    view.count = count_q;
    view.ctrl  = ctrl_q;
    view.intv  = intv_q;
    view.match = match_q;
  end

endmodule

//--- logic/ttc_event_status.sv
// Timer interrupt status and waveform

module ttc_event_status (
  input  logic                          pclk21,
  input  logic                          n_p_reset21,
  input  ttc_pkg::cnt_event_t           evt,       // Event levels from the counter
  input  logic [6:0]                    ctrl,      // Counter control word
  input  logic                          status_rd, // Read of int_status
  input  logic [ttc_pkg::status_w-1:0]  int_en,    // Interrupt mask
  output logic [ttc_pkg::status_w-1:0]  status,
  output logic                          irq,
  output logic                          wave_out
);

  logic [ttc_pkg::status_w-1:0] status_q;
  logic [ttc_pkg::status_w-1:0] evt_bits;   // Events in status order
  ttc_pkg::cnt_event_t          evt_q;      // Last cycle's levels
  logic                         m1_rise;    // First cycle of match 1
  logic                         wrap_rise;  // First cycle of a wrap event
  logic                         wave_q;
  logic                         wave_pol;
  logic                         wave_dis;

  assign evt_bits = evt;
  assign wave_pol = ctrl[ttc_pkg::ctrl_wave_pol];
  assign wave_dis = ctrl[ttc_pkg::ctrl_wave_dis];

  // --------------------------------------------------------------------------
  // Sticky status
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk21 or negedge n_p_reset21)
  begin
    if (!n_p_reset21)
      status_q <= '0;
    else
      status_q <= (status_q & ~{ttc_pkg::status_w{status_rd}}) | evt_bits; // New event beats clear
  end

  assign status = status_q;
  assign irq    = |(status_q & int_en);  // Masked interrupt line

  // --------------------------------------------------------------------------
  // Waveform output
  // --------------------------------------------------------------------------
  assign m1_rise   = evt.match[1] & ~evt_q.match[1];
  assign wrap_rise = (evt.intv & ~evt_q.intv) | (evt.ovf & ~evt_q.ovf);

  always_ff @(posedge pclk21 or negedge n_p_reset21)
  begin
    if (!n_p_reset21)
    begin
      evt_q  <= '0;
      wave_q <= 1'b0;
    end
    else
    begin
      evt_q <= evt;
      if (wave_dis)
        wave_q <= ~wave_pol;     // Idle level
      else if (m1_rise)
        wave_q <= wave_pol;      // Match 1 starts the pulse
      else if (wrap_rise)
        wave_q <= ~wave_pol;     // Wrap ends it
    end
  end

  assign wave_out = wave_q;

endmodule

//--- logic/ttc_channel.sv
// Timer channel top level

module ttc_channel (
  input  logic                        pclk21,
  input  logic                        n_p_reset21,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [ttc_pkg::addr_w-1:0]  paddr,
  input  logic [ttc_pkg::data_w-1:0]  pwdata,
  output logic [ttc_pkg::data_w-1:0]  prdata,
  output logic                        irq,
  output logic                        wave_out
);

  ttc_pkg::reg_wr_t              wr;        // Decoder to counter
  ttc_pkg::tmr_view_t            view;      // Counter registers
  ttc_pkg::cnt_event_t           evt;       // Counter events
  logic [ttc_pkg::status_w-1:0]  status;
  logic [ttc_pkg::status_w-1:0]  int_en;
  logic                          status_rd;
  logic                          presc_en;
  logic [3:0]                    presc_sel;
  logic                          count_en;

  // Bus side
  ttc_reg_decode u_decode (
    .pclk21      (pclk21),
    .n_p_reset21 (n_p_reset21),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .view        (view),
    .status      (status),
    .prdata      (prdata),
    .wr          (wr),
    .status_rd   (status_rd),
    .presc_en    (presc_en),
    .presc_sel   (presc_sel),
    .int_en      (int_en)
  );

  ttc_prescaler u_prescaler (
    .pclk21      (pclk21),
    .n_p_reset21 (n_p_reset21),
    .presc_en    (presc_en),
    .presc_sel   (presc_sel),
    .count_en    (count_en)
  );

  ttc_counter u_counter (
    .pclk21      (pclk21),
    .n_p_reset21 (n_p_reset21),
    .wr          (wr),
    .count_en    (count_en),
    .view        (view),
    .evt         (evt)
  );

  // Status, interrupt and waveform
  ttc_event_status u_event (
    .pclk21      (pclk21),
    .n_p_reset21 (n_p_reset21),
    .evt         (evt),
    .ctrl        (view.ctrl),
    .status_rd   (status_rd),
    .int_en      (int_en),
    .status      (status),
    .irq         (irq),
    .wave_out    (wave_out)
  );

endmodule

//--- bench/ttc_channel_tb.sv
// Timer channel testbench

module ttc_channel_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_cycles = 4000; // Roughly four times the full test run

  logic        pclk21;
  logic        n_p_reset21;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        irq;
  logic        wave_out;

  logic [31:0] lfsr;          // Random source
  int          checks;
  int          errors;
  int          cycles;
  logic        irq_masked;    // Window where irq must stay low
  logic        wave_idle_chk; // Window where wave_out holds its idle level
  logic        wave_idle_lvl;

  ttc_channel dut (
    .pclk21      (pclk21),
    .n_p_reset21 (n_p_reset21),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq),
    .wave_out    (wave_out)
  );

  initial
  begin
    pclk21 = 1'b0;
    forever #4 pclk21 = ~pclk21; // 8 ns period
  end

  // ------------------------------------------------------------------------
  // Concurrent checks
  // ------------------------------------------------------------------------
  irq_stays_low: assert property (@(posedge pclk21) disable iff (!n_p_reset21)
                                  irq_masked |-> !irq)
  else
  begin
    errors++;
    $display("mismatch irq got %h expected %h", irq, 1'b0);
  end

  wave_holds_idle: assert property (@(posedge pclk21) disable iff (!n_p_reset21)
                                    wave_idle_chk |-> (wave_out == wave_idle_lvl))
  else
  begin
    errors++;
    $display("mismatch wave_out got %h expected %h", wave_out, wave_idle_lvl);
  end

  // Hard stop
  initial
  begin
    cycles = 0;
    while (cycles < max_cycles)
    begin
      @(posedge pclk21);
      cycles++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycles);
    $display("TB FAILED");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Helpers, all bus tasks start and end 1 ns after a rising edge
  // ------------------------------------------------------------------------
  task automatic idle(input int n);
    repeat (n)
      @(posedge pclk21);
    #1;
  endtask

  task automatic bus_write(input ttc_pkg::reg_addr_e a, input logic [15:0] d);
    psel    = 1'b1;                // Setup phase
    pwrite  = 1'b1;
    penable = 1'b0;
    paddr   = a;
    pwdata  = d;
    idle(1);
    penable = 1'b1;                // Access phase
    idle(1);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic bus_read(input ttc_pkg::reg_addr_e a, output logic [15:0] d);
    psel    = 1'b1;
    pwrite  = 1'b0;
    penable = 1'b0;
    paddr   = a;
    idle(1);
    penable = 1'b1;
    #2 d    = prdata;              // Mid cycle, well clear of the edge
    idle(1);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic compare_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok)
    else
    begin
      errors++;
      $display("%s", what);
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb}; // One step per bit
      val  = {val[14:0], fb};
    end
    return val;
  endfunction

  // Reference count after a number of count steps
  function automatic logic [15:0] advance(input ttc_pkg::count_mode_e mode,
                                          input logic [15:0] start,
                                          input logic [15:0] intv, input int steps);
    logic [15:0] c;
    c = start;
    for (int i = 0; i < steps; i++)
    begin
      case (mode)
        ttc_pkg::interval_up:   c = (c == intv) ? 16'h0000 : c + 16'h0001;
        ttc_pkg::interval_down: c = (c == 16'h0000) ? intv : c - 16'h0001;
        ttc_pkg::overflow_down: c = c - 16'h0001;  // Wraps through 0
        default:                c = c + 16'h0001;
      endcase
    end
    return c;
  endfunction

  task automatic write_readback(input ttc_pkg::reg_addr_e a, input logic [15:0] d,
                                input logic [15:0] mask);
    logic [15:0] rd;
    bus_write(a, d);
    bus_read(a, rd);
    compare_value(a.name(), rd, d & mask);
  endtask

  // Two count reads a set number of cycles apart
  task automatic check_count_gap(input ttc_pkg::count_mode_e mode, input logic [15:0] intv,
                                 input int gap, input int steps);
    logic [15:0] c1;
    logic [15:0] c2;
    bus_read(ttc_pkg::count_val, c1);
    idle(gap - 2);                   // Read itself takes two
    bus_read(ttc_pkg::count_val, c2);
    compare_value("count_val", c2, advance(mode, c1, intv, steps));
  endtask

  // Restart with the counter held, then read value and control back
  task automatic check_restart(input logic [15:0] ctrl, input logic [15:0] exp);
    logic [15:0] rd;
    bus_write(ttc_pkg::cntr_ctrl, ctrl | 16'h0011);
    idle(2);                         // Restart taken, then one more count_en
    bus_read(ttc_pkg::count_val, rd);
    compare_value("count_val after restart", rd, exp);
    bus_read(ttc_pkg::cntr_ctrl, rd);
    compare_value("cntr_ctrl after restart", rd, ctrl | 16'h0001);
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial
  begin
    logic [15:0] rd;
    logic [15:0] intv_v;
    logic [15:0] m1;
    logic        pol_l;
    int          n;
    int          p;
    int          limit;
    lfsr          = 32'h247;
    checks        = 0;
    errors        = 0;
    irq_masked    = 1'b0;
    wave_idle_chk = 1'b0;
    wave_idle_lvl = 1'b0;
    n_p_reset21   = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = 4'h0;
    pwdata        = 16'h0000;
    repeat (16)
      @(posedge pclk21);
    #1 n_p_reset21 = 1'b1;
    compare_value("irq", 16'(irq), 16'h0000);
    compare_value("wave_out", 16'(wave_out), 16'h0000);

    // Read-only words ignore writes, counter is still held
    bus_write(ttc_pkg::count_val, take_bits(16));
    bus_read(ttc_pkg::count_val, rd);
    compare_value("count_val", rd, 16'h0000);
    bus_write(ttc_pkg::int_status, take_bits(16));
    bus_read(ttc_pkg::int_status, rd);
    compare_value("int_status", rd, 16'h0000);

    for (int r = 0; r < 3; r++)
    begin
      write_readback(ttc_pkg::interval, take_bits(16), 16'hFFFF);
      write_readback(ttc_pkg::match_1, take_bits(16), 16'hFFFF);
      write_readback(ttc_pkg::match_2, take_bits(16), 16'hFFFF);
      write_readback(ttc_pkg::match_3, take_bits(16), 16'hFFFF);
      write_readback(ttc_pkg::cntr_ctrl, take_bits(7) & 16'hFFEF, 16'h007F); // No restart
      write_readback(ttc_pkg::clk_ctrl, take_bits(5), 16'h001F);
      write_readback(ttc_pkg::int_enable, take_bits(5), 16'h001F);
    end
    bus_write(ttc_pkg::clk_ctrl, 16'h0000);      // Prescaler off

    // Overflow up, then held
    bus_write(ttc_pkg::cntr_ctrl, 16'h0000);
    check_count_gap(ttc_pkg::overflow_up, 16'h0000, 13, 13);
    check_count_gap(ttc_pkg::overflow_up, 16'h0000, 37, 37);
    bus_write(ttc_pkg::cntr_ctrl, 16'h0001);
    check_count_gap(ttc_pkg::overflow_up, 16'h0000, 20, 0);

    // Restart values per direction
    intv_v = 16'd16 + take_bits(4);
    bus_write(ttc_pkg::interval, intv_v);
    check_restart(16'h0002, 16'h0000);
    check_restart(16'h0004, 16'hFFFF);
    check_restart(16'h0000, 16'h0000);
    check_restart(16'h0006, intv_v);

    // Interval wrap in both directions
    bus_write(ttc_pkg::cntr_ctrl, 16'h0006);
    check_count_gap(ttc_pkg::interval_down, intv_v, int'(intv_v) + 9, int'(intv_v) + 9);
    bus_write(ttc_pkg::cntr_ctrl, 16'h0002);
    check_count_gap(ttc_pkg::interval_up, intv_v, int'(intv_v) + 9, int'(intv_v) + 9);

    // Interval status with bit 0 masked, then unmasked
    limit = 2 * int'(intv_v) + 4;
    bus_write(ttc_pkg::cntr_ctrl, 16'h0003);
    bus_read(ttc_pkg::int_status, rd);           // Flush old events
    bus_read(ttc_pkg::int_status, rd);
    compare_value("int_status", rd, 16'h0000);
    bus_write(ttc_pkg::int_enable, 16'h001E);
    idle(1);
    irq_masked = 1'b1;
    bus_write(ttc_pkg::cntr_ctrl, 16'h0002);
    idle(limit);
    bus_write(ttc_pkg::cntr_ctrl, 16'h0003);
    irq_masked = 1'b0;
    bus_read(ttc_pkg::int_status, rd);
    compare_value("int_status", rd, 16'h0001);
    bus_read(ttc_pkg::int_status, rd);
    compare_value("int_status", rd, 16'h0000);  // Cleared by the read before
    bus_write(ttc_pkg::int_enable, 16'h0001);
    bus_write(ttc_pkg::cntr_ctrl, 16'h0002);
    n = 0;
    while (!irq && n < limit)
    begin
      idle(1);
      n++;
    end
    check_true(irq, "irq did not rise with the interval interrupt enabled");
    bus_write(ttc_pkg::cntr_ctrl, 16'h0003);
    bus_read(ttc_pkg::int_status, rd);
    compare_value("int_status", rd, 16'h0001);
    compare_value("irq", 16'(irq), 16'h0000);

    // Match events over one full period
    m1 = 16'd1 + take_bits(4);
    bus_write(ttc_pkg::match_1, m1);
    bus_write(ttc_pkg::match_2, 16'd1 + take_bits(4));
    bus_write(ttc_pkg::match_3, 16'd1 + take_bits(4));
    bus_write(ttc_pkg::cntr_ctrl, 16'h000B);
    bus_read(ttc_pkg::int_status, rd);
    bus_write(ttc_pkg::cntr_ctrl, 16'h000A);
    idle(limit);
    bus_write(ttc_pkg::cntr_ctrl, 16'h000B);
    bus_read(ttc_pkg::int_status, rd);
    compare_value("int_status", rd, 16'h000F);

    // Prescaler, m = 3 count steps per window
    bus_write(ttc_pkg::cntr_ctrl, 16'h0000);
    for (int r = 0; r < 2; r++)
    begin
      n = int'(take_bits(2));
      p = 2 << n;                                // 2^(n+1)
      bus_write(ttc_pkg::clk_ctrl, 16'(2 * n + 1));
      idle(4);
      check_count_gap(ttc_pkg::overflow_up, 16'h0000, 3 * p, 3);
    end
    bus_write(ttc_pkg::clk_ctrl, 16'h0000);

    // Waveform, both polarities
    for (int pol = 1; pol >= 0; pol--)
    begin
      pol_l = (pol != 0);
      bus_write(ttc_pkg::cntr_ctrl, pol_l ? 16'h006A : 16'h002A); // Waveform off
      idle(2);
      wave_idle_lvl = ~pol_l;
      wave_idle_chk = 1'b1;
      idle(limit);
      wave_idle_chk = 1'b0;
      bus_write(ttc_pkg::cntr_ctrl, pol_l ? 16'h004A : 16'h000A); // Waveform on
      n = 0;
      while (wave_out != pol_l && n < limit + 4)
      begin
        idle(1);
        n++;
      end
      check_true(wave_out == pol_l, "wave_out never reached its active level");
      n = 0;
      while (wave_out == pol_l && n < 2 * limit)
      begin
        idle(1);
        n++;
      end
      compare_value("wave_out active cycles", 16'(n), intv_v - m1 + 16'd1);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- tb.f
logic/ttc_pkg.sv
logic/ttc_reg_decode.sv
logic/ttc_prescaler.sv
logic/ttc_counter.sv
logic/ttc_event_status.sv
logic/ttc_channel.sv
bench/ttc_channel_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the timer channel testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module ttc_channel_tb \
    -f tb.f -o ttc_sim \
  && ./obj_dir/ttc_sim > sim.log 2>&1 \
  && grep -qx "TB PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
